//--- hw/node_pkg.sv
// shared frame types, register bank type and constants of the chain node, compiled first
package node_pkg;

	// ------------------------------------------------------------------
	// frame layout
	// ------------------------------------------------------------------
	localparam int FRAME_BYTES = 4;
	localparam int BYTE_IDX_W = $clog2(FRAME_BYTES);

	// field order is stream order, dev is the first byte on the wire
	typedef struct packed {
		logic [7:0] dev;
		logic [7:0] mod;
		logic [7:0] addr;
		logic [7:0] data;
	} cmd_t;

	// one frame word, seen as fields or as bytes
	// b[0] lines up with dev, so b[i] is the i-th byte received or sent
	typedef union packed {
		cmd_t f;
		logic [0:FRAME_BYTES-1][7:0] b;
	} cmd_word_u;

	// ------------------------------------------------------------------
	// addressing
	// ------------------------------------------------------------------
	localparam logic [7:0] DEV_BROADCAST = 8'hff;
	localparam logic [7:0] DEV_ID_RESET = 8'h01;

	// set-id is a broadcast to module 0, address 0
	localparam logic [7:0] MOD_SYS = 8'h00;
	localparam logic [7:0] ADDR_SETID = 8'h00;

	// ------------------------------------------------------------------
	// timing, 25 MHz clk_sys
	// ------------------------------------------------------------------
	localparam int CYCLES_PER_US = 25;
	localparam int US_CNT_W = $clog2(CYCLES_PER_US);
	localparam int GAP_US = 4;
	localparam int GAP_CNT_W = $clog2(GAP_US + 1);

	// ------------------------------------------------------------------
	// control register bank, modules 1..4 by addresses 0..3
	// ------------------------------------------------------------------
	localparam int BANK_ROWS = 4;
	localparam int BANK_COLS = 4;
	localparam int BANK_ROW_W = $clog2(BANK_ROWS);
	localparam int BANK_COL_W = $clog2(BANK_COLS);
	localparam logic [7:0] REG_MOD_BASE = 8'h01;
	localparam logic [7:0] REG_MOD_LAST = REG_MOD_BASE + 8'(BANK_ROWS - 1);

	// entry index = row * BANK_COLS + column
	typedef logic [BANK_ROWS*BANK_COLS-1:0][7:0] ctrl_bank_t;

endpackage

//--- hw/us_tick_timer.sv
// microsecond pulse generator and inter-byte gap watchdog feeding the frame collector
`timescale 1ns/1ps

module us_tick_timer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic rx_stb,
	output logic pluse_us,
	output logic gap_timeout
);

	logic [node_pkg::US_CNT_W-1:0] us_cnt;
	logic [node_pkg::GAP_CNT_W-1:0] gap_cnt;
	logic us_wrap;
	logic gap_last;

	assign us_wrap = (us_cnt == node_pkg::US_CNT_W'(node_pkg::CYCLES_PER_US - 1));
	assign gap_last = (gap_cnt == node_pkg::GAP_CNT_W'(node_pkg::GAP_US - 1));

	// ------------------------------------------------------------------
	// free running 1 us pulse
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			us_cnt <= '0;
			pluse_us <= 1'b0;
		end else begin
			pluse_us <= us_wrap;
			if (us_wrap)
				us_cnt <= '0;
			else
				us_cnt <= us_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// gap counter in microseconds since the last byte
	// ------------------------------------------------------------------
	// saturates at GAP_US so the timeout fires only once per gap
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			gap_cnt <= '0;
			gap_timeout <= 1'b0;
		end else begin
			gap_timeout <= !rx_stb && pluse_us && gap_last;
			if (rx_stb)
				gap_cnt <= '0;
			else if (pluse_us && gap_cnt != node_pkg::GAP_CNT_W'(node_pkg::GAP_US))
				gap_cnt <= gap_cnt + 1'b1;
		end
	end

endmodule

//--- hw/frame_collector.sv
// gathers four received bytes into one command frame, dropping partial frames on a gap timeout
`timescale 1ns/1ps

module frame_collector (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [7:0] rx_byte,
	input  logic rx_stb,
	input  logic gap_timeout,
	output node_pkg::cmd_t cmdr,
	output logic cmdr_vld
);

	// state name = number of bytes already held
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_BYTE1 = 2'd1,
		ST_BYTE2 = 2'd2,
		ST_BYTE3 = 2'd3
	} state_t;

	state_t state;
	state_t cur;
	state_t state_nxt;
	node_pkg::cmd_word_u word;
	logic [node_pkg::BYTE_IDX_W-1:0] byte_idx;
	logic frame_done;

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------
	always_comb begin
		// a timeout abandons the partial frame, a byte in the same cycle starts a new one
		cur = gap_timeout ? ST_IDLE : state;
		state_nxt = cur;
		if (rx_stb) begin
			case (cur)
				ST_IDLE:  state_nxt = ST_BYTE1;
				ST_BYTE1: state_nxt = ST_BYTE2;
				ST_BYTE2: state_nxt = ST_BYTE3;
				default:  state_nxt = ST_IDLE;
			endcase
		end
	end

	assign byte_idx = cur;
	assign frame_done = rx_stb && (cur == ST_BYTE3);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cmdr_vld <= 1'b0;
		end else begin
			state <= state_nxt;
			cmdr_vld <= frame_done;
		end
	end

	// ------------------------------------------------------------------
	// frame word, filled in stream order
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rx_stb)
			word.b[byte_idx] <= rx_byte;
	end

	// stable for the cycle after the last byte
	assign cmdr = word.f;

	// at most one frame per four byte strobes
	a_vld_single : assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmdr_vld |=> !cmdr_vld);

endmodule

//--- hw/factory_ctrl.sv
// routes each received frame to the local bank and/or downstream and tracks the device id
`timescale 1ns/1ps

module factory_ctrl (
	input  logic clk_sys,
	input  logic rst_n,
	input  node_pkg::cmd_t cmdr,
	input  logic cmdr_vld,
	output node_pkg::cmd_t cmdl,
	output logic cmdl_vld,
	output node_pkg::cmd_t cmdt,
	output logic cmdt_vld,
	output logic [7:0] dev_id
);

	logic broadcast;
	logic addressed;
	logic cmd_setid;
	logic to_local;
	logic to_fwd;
	logic [7:0] setid_val;

	// ------------------------------------------------------------------
	// frame decode
	// ------------------------------------------------------------------
	assign broadcast = (cmdr.dev == node_pkg::DEV_BROADCAST);
	// a broadcast is never treated as addressed, even if dev_id reached 0xff
	assign addressed = (cmdr.dev == dev_id) && !broadcast;
	assign cmd_setid = broadcast && (cmdr.mod == node_pkg::MOD_SYS) &&
		(cmdr.addr == node_pkg::ADDR_SETID);

	assign to_local = broadcast || addressed;
	assign to_fwd = !addressed;

	// next node in the chain gets one more than we got
	assign setid_val = cmdr.data + 8'd1;

	// ------------------------------------------------------------------
	// device id
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			dev_id <= node_pkg::DEV_ID_RESET;
		else if (cmdr_vld && cmd_setid)
			dev_id <= setid_val;
	end

	// ------------------------------------------------------------------
	// local and forwarded copies
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cmdr_vld) begin
			cmdl <= cmdr;
			cmdt <= cmdr;
			if (cmd_setid)
				cmdt.data <= setid_val;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmdl_vld <= 1'b0;
			cmdt_vld <= 1'b0;
		end else begin
			cmdl_vld <= cmdr_vld && to_local;
			cmdt_vld <= cmdr_vld && to_fwd;
		end
	end

	// both paths only for broadcasts
	a_dual_bcast : assert property (@(posedge clk_sys) disable iff (!rst_n)
		(cmdl_vld && cmdt_vld) |-> (cmdt.dev == node_pkg::DEV_BROADCAST));

endmodule

//--- hw/local_regs.sv
// bank of 8-bit control registers written by frames routed to this node
`timescale 1ns/1ps

module local_regs (
	input  logic clk_sys,
	input  logic rst_n,
	input  node_pkg::cmd_t cmdl,
	input  logic cmdl_vld,
	output node_pkg::ctrl_bank_t ctrl_regs
);

	localparam int IDX_W = node_pkg::BANK_ROW_W + node_pkg::BANK_COL_W;

	logic mod_hit;
	logic addr_hit;
	logic wr_en;
	logic [7:0] row_off;
	logic [IDX_W-1:0] wr_idx;

	// ------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------
	// modules outside 1..4 (set-id included) never touch the bank
	assign mod_hit = (cmdl.mod >= node_pkg::REG_MOD_BASE) &&
		(cmdl.mod <= node_pkg::REG_MOD_LAST);
	assign addr_hit = (cmdl.addr < 8'(node_pkg::BANK_COLS));
	assign wr_en = cmdl_vld && mod_hit && addr_hit;

	// module 1 is row 0
	assign row_off = cmdl.mod - node_pkg::REG_MOD_BASE;

	// row * 4 + column
	assign wr_idx = {row_off[node_pkg::BANK_ROW_W-1:0], cmdl.addr[node_pkg::BANK_COL_W-1:0]};

	// ------------------------------------------------------------------
	// register bank
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			ctrl_regs <= '0;
		else if (wr_en)
			ctrl_regs[wr_idx] <= cmdl.data;
	end

endmodule

//--- hw/frame_sender.sv
// serializes each forwarded frame into four downstream byte strobes
`timescale 1ns/1ps

module frame_sender (
	input  logic clk_sys,
	input  logic rst_n,
	input  node_pkg::cmd_t cmdt,
	input  logic cmdt_vld,
	output logic [7:0] tx_byte,
	output logic tx_stb
);

	node_pkg::cmd_word_u word;
	logic [node_pkg::BYTE_IDX_W-1:0] byte_idx;
	logic busy;
	logic last;

	assign last = busy && (byte_idx == node_pkg::BYTE_IDX_W'(node_pkg::FRAME_BYTES - 1));

	// ------------------------------------------------------------------
	// byte sequencer
	// ------------------------------------------------------------------
	// a new frame may load on the last byte of the current one
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			byte_idx <= '0;
		end else if (cmdt_vld) begin
			busy <= 1'b1;
			byte_idx <= '0;
		end else if (last) begin
			busy <= 1'b0;
			byte_idx <= '0;
		end else if (busy) begin
			byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmdt_vld)
			word.f <= cmdt;
	end

	assign tx_byte = word.b[byte_idx];
	assign tx_stb = busy;

	// no back-pressure, so an early load would cut a frame short
	a_no_overrun : assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmdt_vld |-> (!busy || last));

endmodule

//--- hw/chain_node_top.sv
// one daisy-chain node: byte stream in from upstream, register bank locally, byte stream out
`timescale 1ns/1ps

module chain_node_top (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [7:0] rx_byte,
	input  logic rx_stb,
	output logic [7:0] tx_byte,
	output logic tx_stb,
	output logic [7:0] dev_id,
	output node_pkg::ctrl_bank_t ctrl_regs
);

	logic gap_timeout;
	node_pkg::cmd_t cmdr;
	logic cmdr_vld;
	node_pkg::cmd_t cmdl;
	logic cmdl_vld;
	node_pkg::cmd_t cmdt;
	logic cmdt_vld;

	// ------------------------------------------------------------------
	// receive side
	// ------------------------------------------------------------------
	us_tick_timer u_timer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx_stb      (rx_stb),
		.pluse_us    (),
		.gap_timeout (gap_timeout)
	);

	frame_collector u_collector (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.rx_stb      (rx_stb),
		.gap_timeout (gap_timeout),
		.cmdr        (cmdr),
		.cmdr_vld    (cmdr_vld)
	);

	// ------------------------------------------------------------------
	// routing, local bank, transmit side
	// ------------------------------------------------------------------
	factory_ctrl u_router (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.cmdr     (cmdr),
		.cmdr_vld (cmdr_vld),
		.cmdl     (cmdl),
		.cmdl_vld (cmdl_vld),
		.cmdt     (cmdt),
		.cmdt_vld (cmdt_vld),
		.dev_id   (dev_id)
	);

	local_regs u_regs (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cmdl      (cmdl),
		.cmdl_vld  (cmdl_vld),
		.ctrl_regs (ctrl_regs)
	);

	frame_sender u_sender (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.cmdt     (cmdt),
		.cmdt_vld (cmdt_vld),
		.tx_byte  (tx_byte),
		.tx_stb   (tx_stb)
	);

endmodule

//--- sim/clk_gen.sv
// testbench clock and reset source for the chain node, 25 MHz clock with a 16 cycle reset
`timescale 1ns/1ps

module clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RST_CYCLES = 16;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD_NS) clk_sys = ~clk_sys;
	end

	// release on a rising edge like any other driven input
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

//--- sim/tb_chain_node.sv
// self-checking testbench that runs directed routing cases and random frame streams through one node
`timescale 1ns/1ps

module tb_chain_node;

	logic clk_sys;
	logic rst_n;
	logic [7:0] rx_byte;
	logic rx_stb;
	logic [7:0] tx_byte;
	logic tx_stb;
	logic [7:0] dev_id;
	node_pkg::ctrl_bank_t ctrl_regs;

	logic [31:0] rng;
	int unsigned cyc = 0;
	int tx_bytes = 0;
	logic [7:0] model_id;
	node_pkg::ctrl_bank_t model_bank;
	node_pkg::cmd_t exp_q[$];
	int unsigned start_q[$];

	clk_gen u_clk (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	chain_node_top dut0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_stb    (rx_stb),
		.tx_byte   (tx_byte),
		.tx_stb    (tx_stb),
		.dev_id    (dev_id),
		.ctrl_regs (ctrl_regs)
	);

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	// ------------------------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_frame(input node_pkg::cmd_t got, input node_pkg::cmd_t exp);
		if (got !== exp)
			report_failure($sformatf("FAILED tx_byte frame got %h expected %h", got, exp));
	endtask

	task automatic check_dev_id(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_failure($sformatf("FAILED dev_id got %h expected %h", got, exp));
	endtask

	task automatic check_bank(input node_pkg::ctrl_bank_t got, input node_pkg::ctrl_bank_t exp);
		if (got !== exp)
			report_failure($sformatf("FAILED ctrl_regs got %h expected %h", got, exp));
	endtask

	task automatic check_start(input int unsigned got, input int unsigned exp);
		if (got != exp)
			report_failure($sformatf("FAILED tx_stb first byte cycle got %h expected %h", got, exp));
	endtask

	// ------------------------------------------------------------------
	// random numbers and reference model
	// ------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int n);
		rng = lcg_next(rng);
		return int'(rng[30:16]) % n;
	endfunction

	// updates id and bank, returns 1 when the frame goes downstream
	function automatic logic route_ref(input node_pkg::cmd_t cmd, inout logic [7:0] id,
		inout node_pkg::ctrl_bank_t bank, output node_pkg::cmd_t fwd);
		logic bcast;
		logic here;
		int idx;
		bcast = (cmd.dev == 8'hff);
		here = !bcast && (cmd.dev == id);
		fwd = cmd;
		if (bcast && cmd.mod == 8'h00 && cmd.addr == 8'h00) begin
			id = cmd.data + 8'd1;
			fwd.data = cmd.data + 8'd1;
		end
		// modules 1..4 map to rows 0..3
		if ((bcast || here) && cmd.mod >= 8'd1 && cmd.mod <= 8'd4 && cmd.addr <= 8'd3) begin
			idx = (int'(cmd.mod) - 1) * 4 + int'(cmd.addr);
			bank[idx] = cmd.data;
		end
		return !here;
	endfunction

	// set-id, local write, other device, broadcast write or anything
	function automatic node_pkg::cmd_t random_frame();
		node_pkg::cmd_t c;
		int kind;
		kind = rand_below(5);
		c = {8'(rand_below(256)), 8'(rand_below(256)), 8'(rand_below(256)), 8'(rand_below(256))};
		case (kind)
			0: c = {8'hff, 8'h00, 8'h00, c.data};
			1: c = {model_id, 8'(rand_below(6)), 8'(rand_below(6)), c.data};
			2: begin
				c.dev = model_id + 8'(1 + rand_below(200));
				if (c.dev == 8'hff)
					c.dev = 8'h00;
			end
			3: c = {8'hff, 8'(1 + rand_below(4)), 8'(rand_below(4)), c.data};
			default: ;
		endcase
		return c;
	endfunction

	// ------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			rx_stb <= 1'b0;
		end
	endtask

	task automatic send_bytes(input node_pkg::cmd_t cmd, input int count, input int max_gap);
		logic [31:0] bits;
		node_pkg::cmd_t fwd;
		bits = cmd;
		for (int i = 0; i < count; i++) begin
			if (max_gap > 0)
				idle(rand_below(max_gap + 1));
			@(posedge clk_sys);
			rx_byte <= bits[31 - 8 * i -: 8];
			rx_stb <= 1'b1;
		end
		// only a whole frame reaches the router
		if (count == node_pkg::FRAME_BYTES) begin
			if (route_ref(cmd, model_id, model_bank, fwd)) begin
				exp_q.push_back(fwd);
				// first tx byte in cycle n+3, the negedge count reads one more
				start_q.push_back(cyc + 4);
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			idle(1);
			waited++;
			if (waited > 200)
				report_failure("timeout waiting for forwarded frames on tx");
		end
	endtask

	task automatic check_state();
		idle(4);
		@(negedge clk_sys);
		check_dev_id(dev_id, model_id);
		check_bank(ctrl_regs, model_bank);
	endtask

	// ------------------------------------------------------------------
	// compare process, rebuilds tx frames and matches them in order
	// ------------------------------------------------------------------
	initial begin : compare_tx
		logic [31:0] got_bits;
		int nbytes;
		got_bits = '0;
		nbytes = 0;
		forever begin
			@(negedge clk_sys);
			if (rst_n === 1'b1 && tx_stb) begin
				if (nbytes == 0) begin
					if (exp_q.size() == 0)
						report_failure("tx bytes appeared while no forwarded frame was expected");
					check_start(cyc, start_q.pop_front());
				end
				got_bits = {got_bits[23:0], tx_byte};
				nbytes++;
				tx_bytes++;
				if (nbytes == node_pkg::FRAME_BYTES) begin
					check_frame(got_bits, exp_q.pop_front());
					nbytes = 0;
				end
			end else if (rst_n === 1'b1 && nbytes != 0) begin
				report_failure("tx frame stopped before its fourth byte");
			end
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin : stimulus
		node_pkg::cmd_t c;
		int seen;
		int waited;
		int gap;
		rx_byte = 8'h00;
		rx_stb = 1'b0;
		rng = 32'd44642;
		model_id = 8'h01;
		model_bank = '0;
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk_sys);
			waited++;
			if (waited > 100)
				report_failure("reset was never released");
		end
		check_state();

		// set-id with data 5, frames are {dev, mod, addr, data}
		send_bytes({8'hff, 8'h00, 8'h00, 8'h05}, 4, 0);
		wait_drain();
		check_state();
		check_dev_id(dev_id, 8'h06);

		// local write stays here
		send_bytes({model_id, 8'h03, 8'h02, 8'ha5}, 4, 0);
		seen = tx_bytes;
		idle(20);
		if (tx_bytes != seen)
			report_failure("a frame for this node produced tx bytes");
		check_state();

		// other device passes through, broadcast write does both
		send_bytes({8'h20, 8'h01, 8'h01, 8'h3c}, 4, 0);
		wait_drain();
		check_state();
		send_bytes({8'hff, 8'h02, 8'h03, 8'h5a}, 4, 0);
		wait_drain();
		check_state();

		// partial frame dropped after a gap well over 5 us
		send_bytes({model_id, 8'h01, 8'h00, 8'h77}, 2, 0);
		idle(150);
		send_bytes({8'h33, 8'h04, 8'h02, 8'h99}, 4, 0);
		send_bytes({model_id, 8'h04, 8'h03, 8'hc3}, 4, 0);
		wait_drain();
		check_state();

		// random mix, half back to back
		for (int i = 0; i < 300; i++) begin
			c = random_frame();
			gap = (rand_below(2) == 0) ? 0 : 3;
			send_bytes(c, 4, gap);
		end
		wait_drain();
		check_state();

		$display("Regression passed");
		$finish;
	end

endmodule

//--- files.f
hw/node_pkg.sv
hw/us_tick_timer.sv
hw/frame_collector.sv
hw/factory_ctrl.sv
hw/local_regs.sv
hw/frame_sender.sv
hw/chain_node_top.sv
sim/clk_gen.sv
sim/tb_chain_node.sv

//--- Bender.yml
package:
  name: chain_node

sources:
  - hw/node_pkg.sv
  - hw/us_tick_timer.sv
  - hw/frame_collector.sv
  - hw/factory_ctrl.sv
  - hw/local_regs.sv
  - hw/frame_sender.sv
  - hw/chain_node_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_chain_node.sv
